/* logic/huff_defines.svh */
`ifndef HUFF_DEFINES_SVH
`define HUFF_DEFINES_SVH

// alphabet of 3-bit symbols
`define HUFF_SYMS 8
`define HUFF_SYM_W 3

// histogram counts and tree weights, saturating
`define HUFF_CNT_W 8

// code length field, zero marks an absent symbol
`define HUFF_LEN_W 3

// longest code an 8-symbol tree can produce
`define HUFF_MAX_LEN 7

// credits handed to the source when a block opens
`define HUFF_CREDITS 4

`endif

/* logic/huff_data_pkg.sv */
`include "huff_defines.svh"

package huff_data_pkg;

    // one input symbol
    typedef logic [`HUFF_SYM_W-1:0] sym_t;

    // occurrence count or merged weight
    typedef logic [`HUFF_CNT_W-1:0] count_t;

    // code length, 0 when the symbol never occurred
    typedef logic [`HUFF_LEN_W-1:0] len_t;

    // canonical code, right-aligned in the field
    typedef logic [`HUFF_MAX_LEN-1:0] code_t;

    // input beat from the upstream source
    // last flags the final symbol of a block
    typedef struct packed {
        logic valid;
        sym_t sym;
        logic last;
    } sym_beat_t;

    // one row of the readable code table
    typedef struct packed {
        len_t  len;
        code_t code;
    } code_entry_t;

    // per-symbol arrays passed between the phase units
    // histogram -> tree builder
    typedef count_t [`HUFF_SYMS-1:0] count_arr_t;

    // tree builder -> codebook
    typedef len_t [`HUFF_SYMS-1:0] len_arr_t;

endpackage

/* logic/huff_ctrl_pkg.sv */
package huff_ctrl_pkg;

    // controller phases
    // translation and serial phases are not part of this design
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        HISTO = 3'd1,
        TREE  = 3'd2,
        CBS   = 3'd3,
        DONE  = 3'd4
    } phase_t;

    // finish flags, one per phase, msb first
    // each flag is a level held until its start drops
    typedef struct packed {
        logic idle_fin;
        logic histo_fin;
        logic tree_fin;
        logic cbs_fin;
    } fin_t;

    // start levels, high for the whole phase
    typedef struct packed {
        logic histo;
        logic tree;
        logic cbs;
    } start_t;

endpackage

/* logic/huff_phase_ctrl.sv */
module huff_phase_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  restart,
    input  huff_ctrl_pkg::fin_t   fin,
    output huff_ctrl_pkg::start_t starts,
    output huff_ctrl_pkg::phase_t phase,
    output logic                  done
);

    // registered finish patterns that move the phase forward
    localparam huff_ctrl_pkg::fin_t FIN_IDLE  = 4'b1000;
    localparam huff_ctrl_pkg::fin_t FIN_HISTO = 4'b0100;
    localparam huff_ctrl_pkg::fin_t FIN_TREE  = 4'b0010;
    localparam huff_ctrl_pkg::fin_t FIN_CBS   = 4'b0001;

    huff_ctrl_pkg::fin_t   fin_reg;
    huff_ctrl_pkg::phase_t phase_next;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fin_reg <= '0;
            phase   <= huff_ctrl_pkg::IDLE;
            done    <= 1'b0;
        end else begin
            // start only counts while idle
            fin_reg.idle_fin  <= start && (phase == huff_ctrl_pkg::IDLE);
            fin_reg.histo_fin <= fin.histo_fin;
            fin_reg.tree_fin  <= fin.tree_fin;
            fin_reg.cbs_fin   <= fin.cbs_fin;
            phase             <= phase_next;
            // done tracks the DONE phase cycle for cycle
            done              <= (phase_next == huff_ctrl_pkg::DONE);
        end
    end

    // decode the registered flags
    // a flag only advances the phase that owns it, so a flag still
    // falling after restart cannot pull the phase forward again
    always_comb begin
        phase_next = phase;
        case (fin_reg)
            FIN_IDLE: begin
                if (phase == huff_ctrl_pkg::IDLE) begin
                    phase_next = huff_ctrl_pkg::HISTO;
                end
            end
            FIN_HISTO: begin
                if (phase == huff_ctrl_pkg::HISTO) begin
                    phase_next = huff_ctrl_pkg::TREE;
                end
            end
            FIN_TREE: begin
                if (phase == huff_ctrl_pkg::TREE) begin
                    phase_next = huff_ctrl_pkg::CBS;
                end
            end
            FIN_CBS: begin
                if (phase == huff_ctrl_pkg::CBS) begin
                    phase_next = huff_ctrl_pkg::DONE;
                end
            end
            default: begin
                phase_next = phase;
            end
        endcase
        // restart wins from any phase
        if (restart) begin
            phase_next = huff_ctrl_pkg::IDLE;
        end
    end

    // start levels straight from the phase register
    assign starts.histo = (phase == huff_ctrl_pkg::HISTO);
    assign starts.tree  = (phase == huff_ctrl_pkg::TREE);
    assign starts.cbs   = (phase == huff_ctrl_pkg::CBS);

    // the tree phase sits between counting and code assignment
    // so no tree or codebook finish may reach us while counting
    a_no_histo_to_cbs: assert property (
        @(posedge clk) disable iff (rst)
        phase == huff_ctrl_pkg::HISTO |-> !fin_reg.tree_fin && !fin_reg.cbs_fin
    );

endmodule

/* logic/huff_histogram.sv */
`include "huff_defines.svh"

module huff_histogram (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      go,
    input  huff_data_pkg::sym_beat_t  beat,
    output logic                      credit,
    output huff_data_pkg::count_arr_t counts,
    output logic                      fin
);

    localparam int CRW = $clog2(`HUFF_CREDITS + 1);

    logic           go_d;
    logic           go_rise;
    logic           got_last;
    logic           spend;
    logic           accept;
    logic           issue;
    logic [CRW-1:0] owed;
    logic [CRW-1:0] owed_next;
    logic [CRW-1:0] outst;

    assign go_rise = go && !go_d;
    // every valid beat uses up one source credit
    assign spend   = go && beat.valid;
    // beats after last are dropped
    assign accept  = spend && !got_last && !go_rise;

    // credits still owed to the source
    // opening load plus one per consumed beat, one pulse per cycle
    always_comb begin
        if (go_rise) begin
            issue     = 1'b1;
            owed_next = CRW'(`HUFF_CREDITS - 1);
        end else begin
            issue     = go && ((owed != '0) || accept);
            owed_next = owed + CRW'(accept) - CRW'(issue);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            go_d     <= 1'b0;
            got_last <= 1'b0;
            owed     <= '0;
            outst    <= '0;
            credit   <= 1'b0;
            fin      <= 1'b0;
        end else begin
            go_d   <= go;
            owed   <= owed_next;
            credit <= issue;
            if (go_rise) begin
                got_last <= 1'b0;
                outst    <= '0;
            end else begin
                if (accept && beat.last) begin
                    got_last <= 1'b1;
                end
                // credits held by the source right now
                outst <= outst + CRW'(credit) - CRW'(spend);
            end
            // finished once last is in and every credit has gone back
            fin <= go && !go_rise && (got_last || (accept && beat.last))
                   && (owed_next == '0);
        end
    end

    // count table, cleared as a block opens
    always_ff @(posedge clk) begin
        if (go_rise) begin
            counts <= '0;
        end else if (accept && (counts[beat.sym] != '1)) begin
            counts[beat.sym] <= counts[beat.sym] + 1'b1;
        end
    end

    // a beat needs a credit the source already holds or sees this cycle
    a_beat_has_credit: assert property (
        @(posedge clk) disable iff (rst)
        go && beat.valid |-> (outst != '0) || credit
    );

endmodule

/* logic/huff_tree_builder.sv */
`include "huff_defines.svh"

module huff_tree_builder (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      go,
    input  huff_data_pkg::count_arr_t counts,
    output huff_data_pkg::len_arr_t   lens,
    output logic                      fin
);

    typedef enum logic [1:0] {
        INIT,
        SCAN,
        MERGE,
        FIN
    } tree_state_t;

    localparam huff_data_pkg::sym_t SYM_LAST = huff_data_pkg::sym_t'(`HUFF_SYMS - 1);

    tree_state_t                          state;
    huff_data_pkg::sym_t                  idx;
    huff_data_pkg::count_arr_t            weight;
    logic [`HUFF_SYMS-1:0]                live;
    // group key of each symbol, the symbol index of the group head
    huff_data_pkg::sym_t [`HUFF_SYMS-1:0] grp;

    // lowest (a) and second lowest (b) groups seen so far
    huff_data_pkg::sym_t   a_idx;
    huff_data_pkg::sym_t   b_idx;
    huff_data_pkg::count_t a_w;
    huff_data_pkg::count_t b_w;
    logic                  a_ok;
    logic                  b_ok;
    huff_data_pkg::sym_t   na_idx;
    huff_data_pkg::sym_t   nb_idx;
    huff_data_pkg::count_t na_w;
    huff_data_pkg::count_t nb_w;
    logic                  na_ok;
    logic                  nb_ok;

    huff_data_pkg::sym_t   lo_idx;
    huff_data_pkg::sym_t   hi_idx;
    logic [`HUFF_CNT_W:0]  sum;
    huff_data_pkg::count_t merged_w;

    // fold the group at idx into the running pair
    // strict compare keeps the lower index on ties
    always_comb begin
        na_idx = a_idx;
        na_w   = a_w;
        na_ok  = a_ok;
        nb_idx = b_idx;
        nb_w   = b_w;
        nb_ok  = b_ok;
        if (live[idx]) begin
            if (!a_ok || (weight[idx] < a_w)) begin
                nb_idx = a_idx;
                nb_w   = a_w;
                nb_ok  = a_ok;
                na_idx = idx;
                na_w   = weight[idx];
                na_ok  = 1'b1;
            end else if (!b_ok || (weight[idx] < b_w)) begin
                nb_idx = idx;
                nb_w   = weight[idx];
                nb_ok  = 1'b1;
            end
        end
    end

    // survivor is the lower index of the pair
    assign lo_idx   = (a_idx < b_idx) ? a_idx : b_idx;
    assign hi_idx   = (a_idx < b_idx) ? b_idx : a_idx;
    assign sum      = {1'b0, a_w} + {1'b0, b_w};
    assign merged_w = sum[`HUFF_CNT_W] ? '1 : sum[`HUFF_CNT_W-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= INIT;
            idx   <= '0;
            a_ok  <= 1'b0;
            b_ok  <= 1'b0;
        end else if (!go) begin
            state <= INIT;
        end else begin
            case (state)
                INIT: begin
                    state <= SCAN;
                    idx   <= '0;
                    a_ok  <= 1'b0;
                    b_ok  <= 1'b0;
                end
                SCAN: begin
                    a_ok <= na_ok;
                    b_ok <= nb_ok;
                    idx  <= idx + 1'b1;
                    // one group left ends the tree
                    if (idx == SYM_LAST) begin
                        state <= nb_ok ? MERGE : FIN;
                    end
                end
                MERGE: begin
                    state <= SCAN;
                    idx   <= '0;
                    a_ok  <= 1'b0;
                    b_ok  <= 1'b0;
                end
                default: begin
                    state <= FIN;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            INIT: begin
                // every occurring symbol starts as its own group
                // lens hold while idle, the codebook still reads them
                if (go) begin
                    for (int j = 0; j < `HUFF_SYMS; j++) begin
                        weight[j] <= counts[j];
                        live[j]   <= (counts[j] != '0);
                        grp[j]    <= huff_data_pkg::sym_t'(j);
                        lens[j]   <= '0;
                    end
                end
            end
            SCAN: begin
                a_idx <= na_idx;
                a_w   <= na_w;
                b_idx <= nb_idx;
                b_w   <= nb_w;
                // lone symbol never merged, still needs a 1-bit code
                if ((idx == SYM_LAST) && !nb_ok && na_ok && (lens[na_idx] == '0)) begin
                    lens[na_idx] <= huff_data_pkg::len_t'(1);
                end
            end
            MERGE: begin
                weight[lo_idx] <= merged_w;
                live[hi_idx]   <= 1'b0;
                // members of both groups sink one level
                for (int j = 0; j < `HUFF_SYMS; j++) begin
                    if ((grp[j] == a_idx) || (grp[j] == b_idx)) begin
                        grp[j] <= lo_idx;
                        if (lens[j] != '1) begin
                            lens[j] <= lens[j] + 1'b1;
                        end
                    end
                end
            end
            default: begin
            end
        endcase
    end

    assign fin = (state == FIN);

endmodule

/* logic/huff_codebook.sv */
`include "huff_defines.svh"

module huff_codebook (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        go,
    input  huff_data_pkg::len_arr_t     lens,
    input  huff_data_pkg::sym_t         rd_addr,
    output huff_data_pkg::code_entry_t  rd_entry,
    output logic                        fin
);

    typedef enum logic [1:0] {
        CB_IDLE,
        CB_RUN,
        CB_FIN
    } cb_state_t;

    localparam huff_data_pkg::sym_t SYM_LAST = huff_data_pkg::sym_t'(`HUFF_SYMS - 1);
    localparam huff_data_pkg::len_t LEN_LAST = huff_data_pkg::len_t'(`HUFF_MAX_LEN);

    cb_state_t                                   state;
    huff_data_pkg::len_t                         cur_len;
    huff_data_pkg::sym_t                         cur_sym;
    huff_data_pkg::code_t                        code_val;
    huff_data_pkg::code_t                        code_inc;
    logic                                        hit;
    huff_data_pkg::code_entry_t [`HUFF_SYMS-1:0] tbl;

    // candidate takes the running code when its length matches
    assign hit      = (lens[cur_sym] == cur_len);
    assign code_inc = hit ? code_val + 1'b1 : code_val;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= CB_IDLE;
            cur_len  <= '0;
            cur_sym  <= '0;
            code_val <= '0;
        end else if (!go) begin
            state <= CB_IDLE;
        end else begin
            case (state)
                CB_IDLE: begin
                    state    <= CB_RUN;
                    cur_len  <= huff_data_pkg::len_t'(1);
                    cur_sym  <= '0;
                    code_val <= '0;
                end
                CB_RUN: begin
                    cur_sym <= cur_sym + 1'b1;
                    if (cur_sym == SYM_LAST) begin
                        if (cur_len == LEN_LAST) begin
                            state <= CB_FIN;
                        end else begin
                            // next length, code grows by one bit
                            cur_len  <= cur_len + 1'b1;
                            code_val <= code_inc << 1;
                        end
                    end else begin
                        code_val <= code_inc;
                    end
                end
                default: begin
                    state <= CB_FIN;
                end
            endcase
        end
    end

    // code table
    // cleared on entry so absent symbols read as zero
    always_ff @(posedge clk) begin
        if (go && (state == CB_IDLE)) begin
            tbl <= '0;
        end else if ((state == CB_RUN) && hit) begin
            tbl[cur_sym].len  <= cur_len;
            tbl[cur_sym].code <= code_val;
        end
    end

    // read port, one cycle behind the address
    always_ff @(posedge clk) begin
        rd_entry <= tbl[rd_addr];
    end

    assign fin = (state == CB_FIN);

endmodule

/* logic/huff_encoder_top.sv */
module huff_encoder_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic                       restart,
    input  huff_data_pkg::sym_beat_t   beat,
    input  huff_data_pkg::sym_t        rd_addr,
    output logic                       credit,
    output huff_data_pkg::code_entry_t rd_entry,
    output logic                       done,
    output huff_ctrl_pkg::phase_t      phase
);

    huff_ctrl_pkg::fin_t       unit_fin;
    huff_ctrl_pkg::start_t     starts;
    huff_data_pkg::count_arr_t counts;
    huff_data_pkg::len_arr_t   lens;
    logic                      histo_fin;
    logic                      tree_fin;
    logic                      cbs_fin;

    // idle_fin is built from start inside the controller
    assign unit_fin = '{idle_fin: 1'b0, histo_fin: histo_fin,
                        tree_fin: tree_fin, cbs_fin: cbs_fin};

    huff_phase_ctrl ctrl_i (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .restart (restart),
        .fin     (unit_fin),
        .starts  (starts),
        .phase   (phase),
        .done    (done)
    );

    huff_histogram histo_i (
        .clk    (clk),
        .rst    (rst),
        .go     (starts.histo),
        .beat   (beat),
        .credit (credit),
        .counts (counts),
        .fin    (histo_fin)
    );

    huff_tree_builder tree_i (
        .clk    (clk),
        .rst    (rst),
        .go     (starts.tree),
        .counts (counts),
        .lens   (lens),
        .fin    (tree_fin)
    );

    huff_codebook cbs_i (
        .clk      (clk),
        .rst      (rst),
        .go       (starts.cbs),
        .lens     (lens),
        .rd_addr  (rd_addr),
        .rd_entry (rd_entry),
        .fin      (cbs_fin)
    );

endmodule

/* test/huff_encoder_tb.sv */
`include "huff_defines.svh"

module huff_encoder_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_CASES         = 6;
    localparam int CLK_PERIOD      = 100;
    localparam int WATCHDOG_CYCLES = 400 * N_CASES + 50;

    logic                       clk;
    logic                       rst;
    logic                       start;
    logic                       restart;
    huff_data_pkg::sym_beat_t   beat;
    huff_data_pkg::sym_t        rd_addr;
    logic                       credit;
    huff_data_pkg::code_entry_t rd_entry;
    logic                       done;
    huff_ctrl_pkg::phase_t      phase;

    // stimulus table
    // one nibble per symbol, first symbol in the low nibble
    string       case_name [N_CASES];
    logic [63:0] case_syms [N_CASES];
    int          case_n    [N_CASES];

    // reference table per symbol
    int exp_len  [`HUFF_SYMS];
    int exp_code [`HUFF_SYMS];

    integer seed;
    int     errors;
    int     checks;
    int     cur_case;
    // credits the source holds, and credits seen in this block
    int     held;
    int     credits_seen;

    huff_encoder_top dut_i (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .restart  (restart),
        .beat     (beat),
        .rd_addr  (rd_addr),
        .credit   (credit),
        .rd_entry (rd_entry),
        .done     (done),
        .phase    (phase)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic load_cases();
        int i;
        case_name[0] = "skewed";
        case_syms[0] = 64'h0015_0204_1030_2010;
        case_n[0]    = 15;
        case_name[1] = "uniform";
        case_syms[1] = 64'h7654_3210_7654_3210;
        case_n[1]    = 16;
        case_name[2] = "two_symbol";
        case_syms[2] = 64'h0000_0000_0006_6262;
        case_n[2]    = 5;
        case_name[3] = "single_symbol";
        case_syms[3] = 64'h0000_0000_0000_0555;
        case_n[3]    = 3;
        // no symbol 5 here, so a stale count would show up
        case_name[4] = "fresh_block";
        case_syms[4] = 64'h0000_0000_0071_3771;
        case_n[4]    = 6;
        case_name[5] = "random";
        case_syms[5] = '0;
        case_n[5]    = 12;
        for (i = 0; i < case_n[5]; i++) begin
            case_syms[5][4 * i +: 4] = 4'($random(seed) & 7);
        end
    endtask

    // one clock, credit bookkeeping on the falling edge
    task automatic next_cycle();
        @(negedge clk);
        if (credit) begin
            held++;
            credits_seen++;
            if (phase != huff_ctrl_pkg::HISTO) begin
                errors++;
                $display("credit returned outside the histogram phase (phase %0d)", phase);
            end
            if (held > `HUFF_CREDITS) begin
                errors++;
                $display("source holds %0d credits, more than the credit limit", held);
            end
        end
    endtask

    // huffman lengths with low-index tie break, then canonical codes
    task automatic compute_model(input int c);
        int w   [`HUFF_SYMS];
        int grp [`HUFF_SYMS];
        int n_live;
        int a;
        int b;
        int lo;
        int code;
        int len;
        int i;
        int j;
        for (i = 0; i < `HUFF_SYMS; i++) begin
            w[i]        = 0;
            exp_len[i]  = 0;
            exp_code[i] = 0;
        end
        for (i = 0; i < case_n[c]; i++) begin
            w[int'(huff_data_pkg::sym_t'(case_syms[c] >> (4 * i)))]++;
        end
        // a symbol heads its own group when grp points at itself
        n_live = 0;
        for (i = 0; i < `HUFF_SYMS; i++) begin
            grp[i] = (w[i] > 0) ? i : -1;
            if (w[i] > 0) begin
                n_live++;
            end
        end
        while (n_live > 1) begin
            a = -1;
            b = -1;
            for (i = 0; i < `HUFF_SYMS; i++) begin
                if ((grp[i] == i) && ((a < 0) || (w[i] < w[a]))) begin
                    a = i;
                end
            end
            for (i = 0; i < `HUFF_SYMS; i++) begin
                if ((grp[i] == i) && (i != a) && ((b < 0) || (w[i] < w[b]))) begin
                    b = i;
                end
            end
            lo    = (a < b) ? a : b;
            w[lo] = w[a] + w[b];
            if (w[lo] > 255) begin
                w[lo] = 255;
            end
            for (j = 0; j < `HUFF_SYMS; j++) begin
                if ((grp[j] == a) || (grp[j] == b)) begin
                    grp[j] = lo;
                    if (exp_len[j] < `HUFF_MAX_LEN) begin
                        exp_len[j]++;
                    end
                end
            end
            n_live--;
        end
        // lone symbol still gets a 1-bit code
        for (i = 0; i < `HUFF_SYMS; i++) begin
            if ((grp[i] == i) && (exp_len[i] == 0)) begin
                exp_len[i] = 1;
            end
        end
        code = 0;
        for (len = 1; len <= `HUFF_MAX_LEN; len++) begin
            for (i = 0; i < `HUFF_SYMS; i++) begin
                if (exp_len[i] == len) begin
                    exp_code[i] = code;
                    code++;
                end
            end
            code = code << 1;
        end
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("CHECK FAILED %s: %s expected %0d actual %0d",
                     case_name[cur_case], what, expected, actual);
        end
    endtask

    task automatic run_case(input int c);
        int sent;
        int i;
        cur_case     = c;
        sent         = 0;
        held         = 0;
        credits_seen = 0;
        start        = 1'b1;
        next_cycle();
        start = 1'b0;
        // feed symbols while credits last, with random gaps
        while (!done) begin
            next_cycle();
            beat = '0;
            if ((sent < case_n[c]) && (held > 0) && (($random(seed) & 3) != 0)) begin
                beat.valid = 1'b1;
                beat.sym   = huff_data_pkg::sym_t'(case_syms[c] >> (4 * sent));
                beat.last  = (sent == case_n[c] - 1);
                held--;
                sent++;
            end
        end
        check_value("symbols sent", case_n[c], sent);
        check_value("credits returned", sent + `HUFF_CREDITS, credits_seen);
        compute_model(c);
        // table reads, entry valid one cycle after the address
        for (i = 0; i < `HUFF_SYMS; i++) begin
            rd_addr = huff_data_pkg::sym_t'(i);
            next_cycle();
            check_value($sformatf("len of symbol %0d", i), exp_len[i], int'(rd_entry.len));
            check_value($sformatf("code of symbol %0d", i), exp_code[i] & 127,
                        int'(rd_entry.code));
            if (!done || (phase != huff_ctrl_pkg::DONE)) begin
                errors++;
                $display("done or phase dropped before restart in case %s", case_name[c]);
            end
        end
        restart = 1'b1;
        next_cycle();
        restart = 1'b0;
        check_value("done after restart", 0, int'(done));
        check_value("phase after restart", int'(huff_ctrl_pkg::IDLE), int'(phase));
    endtask

    // ends a run that never reaches the end of the table
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the DUT stopped making progress");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        start        = 1'b0;
        restart      = 1'b0;
        beat         = '0;
        rd_addr      = '0;
        seed         = 20470;
        errors       = 0;
        checks       = 0;
        held         = 0;
        credits_seen = 0;
        cur_case     = 0;
        load_cases();
        repeat (2) @(negedge clk);
        rst = 1'b0;
        check_value("phase after reset", int'(huff_ctrl_pkg::IDLE), int'(phase));
        check_value("done after reset", 0, int'(done));
        check_value("credit after reset", 0, int'(credit));
        for (int c = 0; c < N_CASES; c++) begin
            run_case(c);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+logic
logic/huff_data_pkg.sv
logic/huff_ctrl_pkg.sv
logic/huff_phase_ctrl.sv
logic/huff_histogram.sv
logic/huff_tree_builder.sv
logic/huff_codebook.sv
logic/huff_encoder_top.sv
test/huff_encoder_tb.sv
